// File: verilog/cdc_fifo_pkg.sv
package cdc_fifo_pkg;

    // Payload word width in bits.
    localparam int DATA_WIDTH = 16;

    // Memory address width. Sets the FIFO depth.
    localparam int ADDRESS_WIDTH = 4;

    // Number of storage entries.
    localparam int DEPTH = 2 ** ADDRESS_WIDTH;

    // Pointer carries one extra wrap bit.
    // Equal addresses with differing wrap bits mean full.
    // Equal addresses with equal wrap bits mean empty.
    localparam int POINTER_WIDTH = ADDRESS_WIDTH + 1;

    // One FIFO entry as seen on both ports.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;    // Payload.
        logic                  last;    // End of packet marker.
    } fifo_item_t;

    // Binary or Gray pointer with wrap bit.
    typedef logic [POINTER_WIDTH-1:0] pointer_t;

    // Address part of a pointer.
    typedef logic [ADDRESS_WIDTH-1:0] address_t;

endpackage

// File: verilog/cdc_fifo_pointer_sync.sv
module cdc_fifo_pointer_sync import cdc_fifo_pkg::*; (
    input  logic     source_aclk,
    input  logic     source_areset_n,
    input  pointer_t source_pointer,
    input  logic     destination_aclk,
    input  logic     destination_areset_n,
    output pointer_t destination_pointer
);

    // Adjacent binary values differ in one Gray bit.
    function automatic pointer_t binary_to_gray(input pointer_t binary);
        return binary ^ (binary >> 1);
    endfunction

    // Prefix XOR from the top bit down.
    function automatic pointer_t gray_to_binary(input pointer_t gray);
        pointer_t binary;
        binary[POINTER_WIDTH-1] = gray[POINTER_WIDTH-1];
        for (int i = POINTER_WIDTH - 2; i >= 0; i--) begin
            binary[i] = binary[i + 1] ^ gray[i];
        end
        return binary;
    endfunction

    pointer_t source_gray_q;        // Launch register, source domain.
    pointer_t sync_stage1_q;        // First capture flop. May go metastable.
    pointer_t sync_stage2_q;        // Second flop. Settled value.

    // Gray value registered in source clock so no glitch crosses.
    always_ff @(posedge source_aclk or negedge source_areset_n) begin
        if (!source_areset_n) begin
            source_gray_q <= '0;
        end
        else begin
            source_gray_q <= binary_to_gray(source_pointer);
        end
    end

    // Two flop synchronizer in destination clock.
    always_ff @(posedge destination_aclk or negedge destination_areset_n) begin
        if (!destination_areset_n) begin
            sync_stage1_q <= '0;
            sync_stage2_q <= '0;
        end
        else begin
            sync_stage1_q <= source_gray_q;
            sync_stage2_q <= sync_stage1_q;
        end
    end

    // Back to binary, registered for clean timing into the compare.
    always_ff @(posedge destination_aclk or negedge destination_areset_n) begin
        if (!destination_areset_n) begin
            destination_pointer <= '0;
        end
        else begin
            destination_pointer <= gray_to_binary(sync_stage2_q);
        end
    end

endmodule

// File: verilog/cdc_fifo_write_control.sv
module cdc_fifo_write_control import cdc_fifo_pkg::*; (
    input  logic     write_aclk,
    input  logic     write_areset_n,
    input  logic     write_valid,
    input  pointer_t read_pointer_synced,   // Read pointer, already in write domain.
    output logic     write_ready,
    output logic     memory_write,
    output pointer_t write_pointer
);

    logic     full_q;                       // Registered full flag.
    logic     full_next;
    logic     write_accept;                 // Handshake on this edge.
    pointer_t write_pointer_next;
    pointer_t read_pointer_wrapped;         // Synced read pointer one lap ahead.

    // Ready follows full only. Never looks at valid.
    assign write_ready = !full_q;

    // Word taken when both sides agree.
    assign write_accept = write_valid && write_ready;

    // Strobe into the memory for the accepted word.
    assign memory_write = write_accept;

    // Pointer after this edge.
    assign write_pointer_next = write_pointer + pointer_t'(write_accept);

    // Flip wrap bit. Address bits kept.
    assign read_pointer_wrapped = {
        ~read_pointer_synced[POINTER_WIDTH-1],
        read_pointer_synced[POINTER_WIDTH-2:0]
    };

    // Full when writer is a whole lap ahead of the reader.
    // Uses the next pointer so full rises on the DEPTH-th accept edge.
    assign full_next = (write_pointer_next == read_pointer_wrapped);

    // Write pointer advances on each accepted word.
    always_ff @(posedge write_aclk or negedge write_areset_n) begin
        if (!write_areset_n) begin
            write_pointer <= '0;
        end
        else begin
            write_pointer <= write_pointer_next;
        end
    end

    // Full is re-evaluated every cycle.
    // Clears only after the read pointer change has crossed over.
    always_ff @(posedge write_aclk or negedge write_areset_n) begin
        if (!write_areset_n) begin
            full_q <= 1'b0;                 // Ready high straight out of reset.
        end
        else begin
            full_q <= full_next;
        end
    end

endmodule

// File: verilog/cdc_fifo_read_control.sv
module cdc_fifo_read_control import cdc_fifo_pkg::*; (
    input  logic     read_aclk,
    input  logic     read_areset_n,
    input  logic     read_ready,
    input  pointer_t write_pointer_synced,  // Write pointer, already in read domain.
    output logic     read_valid,
    output pointer_t read_pointer
);

    logic     read_accept;                  // Handshake on this edge.
    pointer_t read_pointer_next;
    logic     not_empty_next;               // Data left after this edge.

    // Word consumed when valid and ready meet.
    assign read_accept = read_valid && read_ready;

    // Pointer after this edge.
    assign read_pointer_next = read_pointer + pointer_t'(read_accept);

    // Empty when both pointers match including the wrap bit.
    // Compare against the next pointer so the last read drops valid at once.
    assign not_empty_next = (read_pointer_next != write_pointer_synced);

    // Read pointer advances on each handshake.
    // Holds under back-pressure so the memory output holds too.
    always_ff @(posedge read_aclk or negedge read_areset_n) begin
        if (!read_areset_n) begin
            read_pointer <= '0;
        end
        else begin
            read_pointer <= read_pointer_next;
        end
    end

    // Valid registered from not empty.
    // Synced write pointer only moves forward, so once valid it stays
    // valid until the word is taken.
    always_ff @(posedge read_aclk or negedge read_areset_n) begin
        if (!read_areset_n) begin
            read_valid <= 1'b0;             // Nothing to read after reset.
        end
        else begin
            read_valid <= not_empty_next;
        end
    end

endmodule

// File: verilog/cdc_fifo_memory.sv
module cdc_fifo_memory import cdc_fifo_pkg::*; (
    input  logic       write_aclk,
    input  logic       memory_write,        // Write strobe from write control.
    input  address_t   write_address,
    input  fifo_item_t write_item,
    input  address_t   read_address,
    output fifo_item_t read_item
);

    // Storage array. Contents need no reset.
    fifo_item_t memory [DEPTH];

    // Synchronous write in write clock.
    always_ff @(posedge write_aclk) begin
        if (memory_write) begin
            memory[write_address] <= write_item;
        end
    end

    // Asynchronous read.
    // Entry at the read address is stable once its pointer has crossed.
    assign read_item = memory[read_address];

endmodule

// File: verilog/cdc_fifo.sv
module cdc_fifo import cdc_fifo_pkg::*; (
    // Write domain.
    input  logic       write_aclk,
    input  logic       write_areset_n,
    input  logic       write_valid,
    output logic       write_ready,
    input  fifo_item_t write_item,
    // Read domain.
    input  logic       read_aclk,
    input  logic       read_areset_n,
    output logic       read_valid,
    input  logic       read_ready,
    output fifo_item_t read_item
);

    logic     memory_write;                 // Write strobe.
    pointer_t write_pointer;                // Write domain.
    pointer_t read_pointer;                 // Read domain.
    pointer_t write_pointer_synced;         // Write pointer seen in read domain.
    pointer_t read_pointer_synced;          // Read pointer seen in write domain.

    // Write side flow control and pointer.
    cdc_fifo_write_control write_control_i (
        .write_aclk          (write_aclk),
        .write_areset_n      (write_areset_n),
        .write_valid         (write_valid),
        .read_pointer_synced (read_pointer_synced),
        .write_ready         (write_ready),
        .memory_write        (memory_write),
        .write_pointer       (write_pointer)
    );

    // Read side flow control and pointer.
    cdc_fifo_read_control read_control_i (
        .read_aclk            (read_aclk),
        .read_areset_n        (read_areset_n),
        .read_ready           (read_ready),
        .write_pointer_synced (write_pointer_synced),
        .read_valid           (read_valid),
        .read_pointer         (read_pointer)
    );

    // Storage. Addresses are the pointers without the wrap bit.
    cdc_fifo_memory memory_i (
        .write_aclk    (write_aclk),
        .memory_write  (memory_write),
        .write_address (write_pointer[ADDRESS_WIDTH-1:0]),
        .write_item    (write_item),
        .read_address  (read_pointer[ADDRESS_WIDTH-1:0]),
        .read_item     (read_item)
    );

    // Write pointer crossing into the read domain.
    cdc_fifo_pointer_sync write_pointer_sync_i (
        .source_aclk          (write_aclk),
        .source_areset_n      (write_areset_n),
        .source_pointer       (write_pointer),
        .destination_aclk     (read_aclk),
        .destination_areset_n (read_areset_n),
        .destination_pointer  (write_pointer_synced)
    );

    // Read pointer crossing into the write domain.
    cdc_fifo_pointer_sync read_pointer_sync_i (
        .source_aclk          (read_aclk),
        .source_areset_n      (read_areset_n),
        .source_pointer       (read_pointer),
        .destination_aclk     (write_aclk),
        .destination_areset_n (write_areset_n),
        .destination_pointer  (read_pointer_synced)
    );

endmodule

// File: tb/cdc_fifo_tb_tests.svh
// Offers one word, holds it until write_ready is seen at a falling edge.
// Handshake then lands on the next rising edge.
task automatic push_word(input fifo_item_t item);
    int waited = 0;
    @(negedge write_aclk);
    write_valid = 1'b1;
    write_item = item;
    while (!write_ready && waited < WAIT_LIMIT) begin
        @(negedge write_aclk);
        waited++;
    end
    if (write_ready) begin
        expected_items.push_back(item);     // Taken on the coming edge.
        write_count++;
    end
    else begin
        report_failure("Timed out waiting for write_ready to accept a word.");
        write_valid = 1'b0;
    end
endtask

// One idle write cycle.
task automatic stop_write();
    @(negedge write_aclk);
    write_valid = 1'b0;
endtask

task automatic wait_write_ready();
    int waited = 0;
    @(negedge write_aclk);
    while (!write_ready && waited < WAIT_LIMIT) begin
        @(negedge write_aclk);
        waited++;
    end
    if (!write_ready) report_failure("Timed out waiting for write_ready to return high.");
endtask

task automatic wait_read_valid();
    int waited = 0;
    @(negedge read_aclk);
    while (!read_valid && waited < WAIT_LIMIT) begin
        @(negedge read_aclk);
        waited++;
    end
    if (!read_valid) report_failure("Timed out waiting for read_valid to rise.");
endtask

// One read cycle with the given ready. Checks held outputs and popped words.
task automatic read_cycle(input logic ready_value, output logic taken);
    fifo_item_t expected;
    @(negedge read_aclk);
    read_ready = ready_value;
    if (read_stalled) begin                 // Stalled word is still the oldest one.
        check_value("read_valid", 32'd1, 32'(read_valid));
        if (expected_items.size() != 0) begin
            check_value("read_item.data", 32'(expected_items[0].data), 32'(read_item.data));
            check_value("read_item.last", 32'(expected_items[0].last), 32'(read_item.last));
        end
        else begin
            report_failure("A word was held while no word was expected.");
        end
    end
    taken = read_valid && ready_value;
    if (taken) begin
        read_count++;
        if (expected_items.size() == 0) begin
            report_failure("A word was read while no word was expected.");
        end
        else begin
            expected = expected_items.pop_front();
            check_value("read_item.data", 32'(expected.data), 32'(read_item.data));
            check_value("read_item.last", 32'(expected.last), 32'(read_item.last));
        end
    end
    read_stalled = read_valid && !ready_value;
endtask

task automatic test_reset_state();
    int errors_before = error_count;
    @(negedge read_aclk);
    check_value("read_valid", 32'd0, 32'(read_valid));
    @(negedge write_aclk);
    check_value("write_ready", 32'd1, 32'(write_ready));
    report_test("reset_state", errors_before);
endtask

task automatic test_single_transfer();
    int         errors_before = error_count;
    fifo_item_t item;
    logic       taken;
    item = random_item();
    item.last = 1'b1;
    push_word(item);
    stop_write();
    wait_read_valid();
    read_cycle(1'b1, taken);
    check_value("read handshake", 32'd1, 32'(taken));
    read_cycle(1'b0, taken);                // FIFO empty again.
    check_value("read_valid", 32'd0, 32'(read_valid));
    report_test("single_transfer", errors_before);
endtask

task automatic test_full_flag();
    int errors_before = error_count;
    int writes_before;
    repeat (SETTLE_CYCLES) @(negedge write_aclk);   // Last read pointer crosses.
    writes_before = write_count;
    for (int i = 0; i < DEPTH; i++) begin
        push_word(random_item());
    end
    // Words offered while full. Refused and never queued.
    for (int i = 0; i < 4; i++) begin
        @(negedge write_aclk);
        write_item = random_item();
        check_value("write_ready", 32'd0, 32'(write_ready));
    end
    stop_write();
    check_value("accepted writes", 32'(DEPTH), 32'(write_count - writes_before));
    report_test("full_flag", errors_before);
endtask

task automatic test_drain_backpressure();
    int   errors_before = error_count;
    int   taken_count = 0;
    int   idle = 0;
    logic taken;
    while (taken_count < DEPTH && idle < WAIT_LIMIT) begin
        read_cycle(random_bit(), taken);
        if (taken) begin
            taken_count++;
            idle = 0;
        end
        else begin
            idle++;
        end
    end
    if (taken_count < DEPTH) report_failure("Timed out draining the full FIFO.");
    read_cycle(1'b0, taken);
    check_value("read_valid", 32'd0, 32'(read_valid));
    check_value("expected queue size", 32'd0, 32'(expected_items.size()));
    wait_write_ready();                     // Freed space seen by the writer.
    report_test("drain_backpressure", errors_before);
endtask

task automatic test_streaming();
    int errors_before = error_count;
    int writes_before = write_count;
    int reads_before = read_count;
    fork
        begin
            int r;
            for (int i = 0; i < STREAM_COUNT; i++) begin
                r = $random(seed);
                if (r[3:2] == 2'b00) repeat (int'(r[1:0]) + 1) stop_write();  // Gap.
                push_word(random_item());
            end
            stop_write();
        end
        begin
            int   taken_count = 0;
            int   idle = 0;
            logic taken;
            while (taken_count < STREAM_COUNT && idle < WAIT_LIMIT) begin
                read_cycle(random_mostly_high(), taken);
                if (taken) begin
                    taken_count++;
                    idle = 0;
                end
                else begin
                    idle++;
                end
            end
            if (taken_count < STREAM_COUNT) report_failure("Timed out waiting for streamed words.");
            read_cycle(1'b0, taken);
        end
    join
    check_value("stream reads", 32'(write_count - writes_before), 32'(read_count - reads_before));
    check_value("expected queue size", 32'd0, 32'(expected_items.size()));
    check_value("read_valid", 32'd0, 32'(read_valid));
    report_test("streaming", errors_before);
endtask

// File: tb/cdc_fifo_tb.sv
module cdc_fifo_tb import cdc_fifo_pkg::*; ();

    localparam int READ_HALF_PERIOD = 4;    // Read clock period 8.
    localparam int WRITE_LOW_TIME   = 6;    // Write clock period 11.
    localparam int WRITE_HIGH_TIME  = 5;
    localparam int RESET_CYCLES     = 8;
    localparam int WAIT_LIMIT       = 200;  // Cycles before a wait gives up.
    localparam int SETTLE_CYCLES    = 6;    // Covers the 3 to 4 edge pointer crossing.
    localparam int STREAM_COUNT     = 200;

    logic       read_aclk = 1'b0;
    logic       write_aclk = 1'b0;
    logic       read_areset_n;
    logic       write_areset_n;
    logic       write_valid;
    logic       write_ready;
    fifo_item_t write_item;
    logic       read_valid;
    logic       read_ready;
    fifo_item_t read_item;

    fifo_item_t expected_items [$];         // Accepted writes, oldest first.
    int         seed = 32'h476b;
    int         check_count = 0;
    int         error_count = 0;
    int         write_count = 0;            // Accepted writes so far.
    int         read_count = 0;             // Accepted reads so far.
    logic       read_stalled = 1'b0;        // Valid word held by low ready.

    always #READ_HALF_PERIOD read_aclk = ~read_aclk;

    // Odd period so the two clocks keep drifting.
    always begin
        #WRITE_LOW_TIME write_aclk = 1'b1;
        #WRITE_HIGH_TIME write_aclk = 1'b0;
    end

    cdc_fifo dut_i (
        .write_aclk     (write_aclk),
        .write_areset_n (write_areset_n),
        .write_valid    (write_valid),
        .write_ready    (write_ready),
        .write_item     (write_item),
        .read_aclk      (read_aclk),
        .read_areset_n  (read_areset_n),
        .read_valid     (read_valid),
        .read_ready     (read_ready),
        .read_item      (read_item)
    );

    // Compares two values, logs a mismatch in hex.
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s expected 0x%0h, got 0x%0h at time %0t.",
                     name, expected, actual, $time);
        end
    endtask

    // Failure that is not a value mismatch.
    task automatic report_failure(input string reason);
        error_count++;
        $display("Error at time %0t: %s", $time, reason);
    endtask

    // One line per finished test.
    task automatic report_test(input string name, input int errors_before);
        $display("Test %s finished with %0d errors.", name, error_count - errors_before);
    endtask

    function automatic fifo_item_t random_item();
        fifo_item_t item;
        int         r;
        r = $random(seed);
        item.data = r[DATA_WIDTH-1:0];
        item.last = r[DATA_WIDTH];          // Bit above the payload.
        return item;
    endfunction

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // High three times out of four.
    function automatic logic random_mostly_high();
        int r;
        r = $random(seed);
        return r[1:0] != 2'b00;
    endfunction

    `include "cdc_fifo_tb_tests.svh"

    initial begin
        read_areset_n = 1'b0;
        write_areset_n = 1'b0;
        write_valid = 1'b0;
        write_item = '0;
        read_ready = 1'b0;
        // Each reset released on its own falling edge.
        fork
            begin
                repeat (RESET_CYCLES) @(negedge read_aclk);
                read_areset_n = 1'b1;
            end
            begin
                repeat (RESET_CYCLES) @(negedge write_aclk);
                write_areset_n = 1'b1;
            end
        join
        test_reset_state();
        test_single_transfer();
        test_full_flag();
        test_drain_backpressure();
        test_streaming();
        $display("Summary: %0d checks, %0d errors, %0d writes, %0d reads.",
                 check_count, error_count, write_count, read_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end
        else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tb
verilog/cdc_fifo_pkg.sv
verilog/cdc_fifo_pointer_sync.sv
verilog/cdc_fifo_write_control.sv
verilog/cdc_fifo_read_control.sv
verilog/cdc_fifo_memory.sv
verilog/cdc_fifo.sv
tb/cdc_fifo_tb.sv

// File: run.sh
#!/bin/sh
# Builds and runs the cdc_fifo testbench with Verilator.
# Exit status is nonzero when the log reports a failure.

LOG=sim.log

rm -f "$LOG"

# A build or run error is logged as a failure too.
{ verilator --binary --timing -j 0 --top-module cdc_fifo_tb -f verilog.f -o cdc_fifo_sim &&
    ./obj_dir/cdc_fifo_sim; } > "$LOG" 2>&1 ||
    echo "CHECKS FAILED" >> "$LOG"

cat "$LOG"

grep -q "CHECKS FAILED" "$LOG" && echo "Result: fail" && exit 1
echo "Result: pass"
exit 0
